/* build.f */
+incdir+.
sb_flit_pkg.sv
sb_msg_pkg.sv
sb_byte_counter.sv
sb_hier_splitter.sv
sb_dword_assembler.sv
sb_target_port.sv
sb_hier_target.sv
tb_clock_gen.sv
tb_sb_hier_target.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_sb_hier_target
RTL_TOP   ?= sb_hier_target
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_sb_hier_target.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

// Testbench for the two-channel sideband target
module tb_sb_hier_target;

    import sb_flit_pkg::*;
    import sb_msg_pkg::*;

    localparam int PLD_W        = 8;
    localparam int FLITS_PER_DW = `SB_DW_WIDTH / PLD_W;
    localparam int CLK_NS       = 4;
    localparam int RESET_CYC    = 16;
    // Messages per channel in the random traffic test
    localparam int RAND_MSGS    = 30;
    // Directed tests send 8, 4, 4 and 8 messages before the random one
    localparam int TOTAL_MSGS   = 8 + 4 + 4 + 8 + 2 * RAND_MSGS;
    localparam int WATCHDOG_NS  = (TOTAL_MSGS * 200 + RESET_CYC) * CLK_NS;
    // Cycles a test waits for its outstanding deliveries to finish
    localparam int DRAIN_CYC    = 600;

    // Handshake phases as seen from the link and the agent
    localparam int PH_IDLE = 0;
    localparam int PH_RECV = 1;
    localparam int PH_EOM  = 2;
    localparam int PH_REQ  = 3;
    localparam int PH_ACK  = 4;

    logic              side_clk;
    logic              side_rst_b;
    // Both channels are held in arrays indexed by sb_chan_e
    sb_flit_t [1:0]    flit_drv;
    logic [1:0]        ack_drv;
    logic [1:0]        avail_obs;
    logic [1:0]        req_obs;
    sb_msg_rec_t [1:0] rec_obs;

    int seed = 12415;
    int errors;
    int tx_cnt [2];
    int rx_cnt [2];
    // Expected records in send order, one queue per channel
    sb_msg_rec_t pc_exp_q[$];
    sb_msg_rec_t np_exp_q[$];

    tb_clock_gen #(
        .PERIOD_NS (CLK_NS)
    ) clk_gen (
        .side_clk (side_clk)
    );

    sb_hier_target #(
        .PLD_WIDTH (PLD_W)
    ) dut0 (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .pc_flit    (flit_drv[PC]),
        .np_flit    (flit_drv[NP]),
        .pc_avail   (avail_obs[PC]),
        .np_avail   (avail_obs[NP]),
        .pc_rec     (rec_obs[PC]),
        .np_rec     (rec_obs[NP]),
        .pc_req     (req_obs[PC]),
        .np_req     (req_obs[NP]),
        .pc_ack     (ack_drv[PC]),
        .np_ack     (ack_drv[NP])
    );

    // ----------------------------------------------------------------------
    // Sender
    // ----------------------------------------------------------------------

    // Sends one message and queues the record it has to produce
    // A bad_flit of -1 keeps every parity bit correct
    task automatic send_msg(input sb_chan_e ch, input int n_lcl, input int bad_flit,
                            input int max_idle);
        logic [`SB_DW_WIDTH-1:0] dw [`SB_MAX_LCL_DW+1];
        sb_msg_rec_t exp;
        sb_flit_t    f;
        int          n_flits;
        int          idle;
        n_flits = (n_lcl + 1) * FLITS_PER_DW;
        exp = '0;
        for (int i = 0; i <= n_lcl; i++) begin
            dw[i] = $random(seed);
        end
        // First dword is the header, the rest fill lcl from element 0
        exp.hdr     = dw[0];
        exp.lcl_cnt = 3'(n_lcl);
        for (int i = 0; i < n_lcl; i++) begin
            exp.lcl[i] = dw[i+1];
        end
        exp.perr = (bad_flit >= 0);
        // A message may only start while the channel buffer is free
        do begin
            @(negedge side_clk);
        end while (!avail_obs[ch]);
        if (ch == PC) begin
            pc_exp_q.push_back(exp);
        end else begin
            np_exp_q.push_back(exp);
        end
        tx_cnt[ch]++;
        for (int k = 0; k < n_flits; k++) begin
            idle = {$random(seed)} % (max_idle + 1);
            repeat (idle) begin
                @(posedge side_clk);
                #1;
                flit_drv[ch] = '0;
            end
            // Little endian, flit k carries bits k*PLD_W upward
            f.payload = dw[k / FLITS_PER_DW][(k % FLITS_PER_DW) * PLD_W +: PLD_W];
            f.put     = 1'b1;
            f.eom     = (k == n_flits - 1);
            f.msgip   = !f.eom;
            // Even parity, flipped on the chosen flit
            f.parity  = (^f.payload) ^ (k == bad_flit);
            @(posedge side_clk);
            #1;
            flit_drv[ch] = f;
        end
        @(posedge side_clk);
        #1;
        flit_drv[ch] = '0;
    endtask

    // Random lengths from header-only up to a full record, about one in
    // eight messages with a parity error somewhere
    task automatic random_traffic(input sb_chan_e ch, input int count, input int max_idle);
        int n_lcl;
        int bad;
        for (int i = 0; i < count; i++) begin
            n_lcl = {$random(seed)} % (`SB_MAX_LCL_DW + 1);
            bad = -1;
            if ({$random(seed)} % 8 == 0) begin
                bad = {$random(seed)} % ((n_lcl + 1) * FLITS_PER_DW);
            end
            send_msg(ch, n_lcl, bad, max_idle);
        end
    endtask

    // ----------------------------------------------------------------------
    // Agent model and record checks
    // ----------------------------------------------------------------------

    task automatic compare_rec(input sb_chan_e ch, input sb_msg_rec_t got,
                               input sb_msg_rec_t exp);
        assert (got.hdr === exp.hdr) else begin
            $display("error %0t ns: %s hdr %h, expected %h", $time, ch.name(), got.hdr,
                     exp.hdr);
            errors++;
        end
        assert (got.lcl_cnt === exp.lcl_cnt) else begin
            $display("error %0t ns: %s lcl_cnt %0d, expected %0d", $time, ch.name(),
                     got.lcl_cnt, exp.lcl_cnt);
            errors++;
        end
        assert (got.lcl === exp.lcl) else begin
            $display("error %0t ns: %s lcl %h, expected %h", $time, ch.name(), got.lcl,
                     exp.lcl);
            errors++;
        end
        assert (got.perr === exp.perr) else begin
            $display("error %0t ns: %s perr %b, expected %b", $time, ch.name(), got.perr,
                     exp.perr);
            errors++;
        end
    endtask

    // Answers each req with ack after a random delay, then drops ack
    // once req has fallen
    task automatic answer_req(input sb_chan_e ch);
        sb_msg_rec_t exp;
        int          delay;
        forever begin
            @(negedge side_clk);
            if (req_obs[ch]) begin
                if ((ch == PC ? pc_exp_q.size() : np_exp_q.size()) == 0) begin
                    $display("%s raised req at %0t ns although no message was sent",
                             ch.name(), $time);
                    errors++;
                end else begin
                    exp = (ch == PC) ? pc_exp_q.pop_front() : np_exp_q.pop_front();
                    compare_rec(ch, rec_obs[ch], exp);
                end
                delay = {$random(seed)} % 6;
                repeat (delay) @(posedge side_clk);
                @(posedge side_clk);
                #1;
                ack_drv[ch] = 1'b1;
                do begin
                    @(negedge side_clk);
                end while (req_obs[ch]);
                @(posedge side_clk);
                #1;
                ack_drv[ch] = 1'b0;
                rx_cnt[ch]++;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Handshake timing
    // ----------------------------------------------------------------------

    // Tracks the phase from put, eom and ack alone and checks avail and req
    // every cycle, so every latency of the handshake is checked exactly
    task automatic watch_handshake(input sb_chan_e ch);
        int phase;
        int next;
        phase = PH_IDLE;
        forever begin
            @(negedge side_clk);
            assert (avail_obs[ch] === (phase == PH_IDLE) && req_obs[ch] === (phase == PH_REQ))
            else begin
                $display("error %0t ns: %s avail %b req %b, expected avail %b req %b",
                         $time, ch.name(), avail_obs[ch], req_obs[ch], phase == PH_IDLE,
                         phase == PH_REQ);
                errors++;
            end
            next = phase;
            case (phase)
                PH_IDLE: if (flit_drv[ch].put) next = flit_drv[ch].eom ? PH_EOM : PH_RECV;
                PH_RECV: if (flit_drv[ch].put && flit_drv[ch].eom) next = PH_EOM;
                PH_EOM:  next = PH_REQ;
                PH_REQ:  if (ack_drv[ch]) next = PH_ACK;
                PH_ACK:  if (!ack_drv[ch]) next = PH_IDLE;
                default: next = PH_IDLE;
            endcase
            phase = next;
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequencing
    // ----------------------------------------------------------------------

    // Waits until every sent message went through the full handshake
    task automatic drain_deliveries();
        int  waited;
        logic idle;
        waited = 0;
        idle = 1'b0;
        while (!idle && waited < DRAIN_CYC) begin
            @(negedge side_clk);
            waited++;
            idle = (rx_cnt[PC] == tx_cnt[PC]) && (rx_cnt[NP] == tx_cnt[NP]) &&
                   (avail_obs == 2'b11);
        end
        if (!idle) begin
            $display("deliveries did not complete within %0d cycles, pc %0d of %0d, np %0d of %0d",
                     DRAIN_CYC, rx_cnt[PC], tx_cnt[PC], rx_cnt[NP], tx_cnt[NP]);
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name, input int msgs,
                            input int err_mark);
        $display("test %0d %s done, %0d messages, %0d errors", num, name, msgs,
                 errors - err_mark);
    endtask

    initial begin
        int err_mark;
        side_rst_b = 1'b0;
        flit_drv   = '0;
        ack_drv    = '0;
        errors     = 0;
        tx_cnt     = '{0, 0};
        rx_cnt     = '{0, 0};
        repeat (RESET_CYC) @(posedge side_clk);
        #1;
        side_rst_b = 1'b1;
        fork
            watch_handshake(PC);
            watch_handshake(NP);
            answer_req(PC);
            answer_req(NP);
        join_none

        // Both buffers free and no delivery pending out of reset
        err_mark = errors;
        @(negedge side_clk);
        assert (avail_obs === 2'b11 && req_obs === 2'b00) else begin
            $display("error %0t ns: after reset avail %b req %b, expected 11 and 00",
                     $time, avail_obs, req_obs);
            errors++;
        end
        end_test(1, "reset state", 0, err_mark);

        err_mark = errors;
        fork
            for (int n = 1; n <= `SB_MAX_LCL_DW; n++) send_msg(PC, n, -1, 2);
            for (int n = 1; n <= `SB_MAX_LCL_DW; n++) send_msg(NP, n, -1, 2);
        join
        drain_deliveries();
        end_test(2, "header plus local dwords", 8, err_mark);

        // Header-only messages come back with lcl_cnt zero
        err_mark = errors;
        fork
            repeat (2) send_msg(PC, 0, -1, 1);
            repeat (2) send_msg(NP, 0, -1, 1);
        join
        drain_deliveries();
        end_test(3, "single dword", 4, err_mark);

        // Header flit on pc and local flit on np, then a clean message each
        err_mark = errors;
        fork
            begin
                send_msg(PC, 2, {$random(seed)} % FLITS_PER_DW, 1);
                send_msg(PC, 2, -1, 1);
            end
            begin
                send_msg(NP, 2, FLITS_PER_DW + {$random(seed)} % (2 * FLITS_PER_DW), 1);
                send_msg(NP, 2, -1, 1);
            end
        join
        drain_deliveries();
        end_test(4, "parity error", 4, err_mark);

        // Back-to-back flits leave the handshake as the only slack
        err_mark = errors;
        fork
            random_traffic(PC, 4, 0);
            random_traffic(NP, 4, 0);
        join
        drain_deliveries();
        end_test(5, "handshake timing", 8, err_mark);

        err_mark = errors;
        fork
            random_traffic(PC, RAND_MSGS, 3);
            random_traffic(NP, RAND_MSGS, 3);
        join
        drain_deliveries();
        end_test(6, "random traffic on both channels", 2 * RAND_MSGS, err_mark);

        $display("6 tests, %0d messages sent, %0d delivered, %0d errors",
                 tx_cnt[PC] + tx_cnt[NP], rx_cnt[PC] + rx_cnt[NP], errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Allows 200 cycles per message on top of reset
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all tests completed", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Free-running clock for the testbench, starting low
module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic side_clk
);

    initial begin
        side_clk = 1'b0;
    end

    // Half a period low, then half a period high
    always begin
        #(PERIOD_NS / 2);
        side_clk = ~side_clk;
    end

endmodule

`default_nettype wire

/* sb_hier_target.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

// Target side of the sideband endpoint, posted and non-posted channels
module sb_hier_target #(
    parameter int PLD_WIDTH = `SB_PLD_WIDTH
) (
    input  logic                    side_clk,
    input  logic                    side_rst_b,
    input  sb_flit_pkg::sb_flit_t   pc_flit,
    input  sb_flit_pkg::sb_flit_t   np_flit,
    output logic                    pc_avail,
    output logic                    np_avail,
    output sb_msg_pkg::sb_msg_rec_t pc_rec,
    output sb_msg_pkg::sb_msg_rec_t np_rec,
    output logic                    pc_req,
    output logic                    np_req,
    input  logic                    pc_ack,
    input  logic                    np_ack
);

    // ----------------------------------------------------------------------
    // The channels share nothing and run independently
    // ----------------------------------------------------------------------

    sb_target_port #(
        .PLD_WIDTH (PLD_WIDTH)
    ) pc_port (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .flit_in    (pc_flit),
        .avail      (pc_avail),
        .rec        (pc_rec),
        .req        (pc_req),
        .ack        (pc_ack)
    );

    sb_target_port #(
        .PLD_WIDTH (PLD_WIDTH)
    ) np_port (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .flit_in    (np_flit),
        .avail      (np_avail),
        .rec        (np_rec),
        .req        (np_req),
        .ack        (np_ack)
    );

endmodule

`default_nettype wire

/* sb_target_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

// One channel of the target: split, assemble, buffer and hand over
module sb_target_port #(
    parameter int PLD_WIDTH = `SB_PLD_WIDTH
) (
    input  logic                    side_clk,
    input  logic                    side_rst_b,
    input  sb_flit_pkg::sb_flit_t   flit_in,
    output logic                    avail,
    output sb_msg_pkg::sb_msg_rec_t rec,
    output logic                    req,
    input  logic                    ack
);

    import sb_flit_pkg::*;
    import sb_msg_pkg::*;

    // IDLE accepts a message, RECV collects it, REQ and DROP run the
    // four-phase handshake with the agent
    typedef enum logic [1:0] {
        S_IDLE,
        S_RECV,
        S_REQ,
        S_DROP
    } port_state_e;

    port_state_e  state;
    sb_flit_t     hdr_flit;
    sb_flit_t     lcl_flit;
    sb_hier_hdr_t hdr_word;
    sb_lcl_data_t lcl_word;
    logic [2:0]   lcl_dw_cnt;
    logic         hdr_perr;
    logic         lcl_perr;
    logic         hdr_asm_done;
    logic         lcl_asm_done;
    logic         msg_done;

    sb_hier_splitter #(
        .PLD_WIDTH (PLD_WIDTH)
    ) u_splitter (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .flit_in    (flit_in),
        .hdr_flit   (hdr_flit),
        .lcl_flit   (lcl_flit)
    );

    // Header path only ever holds one dword, so its count is not needed
    sb_dword_assembler #(
        .PLD_WIDTH (PLD_WIDTH),
        .out_t     (sb_hier_hdr_t)
    ) u_hdr_asm (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .flit       (hdr_flit),
        .word       (hdr_word),
        .dw_cnt     (),
        .perr       (hdr_perr),
        .done       (hdr_asm_done)
    );

    sb_dword_assembler #(
        .PLD_WIDTH (PLD_WIDTH),
        .out_t     (sb_lcl_data_t)
    ) u_lcl_asm (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .flit       (lcl_flit),
        .word       (lcl_word),
        .dw_cnt     (lcl_dw_cnt),
        .perr       (lcl_perr),
        .done       (lcl_asm_done)
    );

    // Done pulses one cycle after the eom put
    assign msg_done = hdr_asm_done | lcl_asm_done;

    // ----------------------------------------------------------------------
    // Buffer control and handshake
    // ----------------------------------------------------------------------

    always_ff @(posedge side_clk or negedge side_rst_b) begin
        if (!side_rst_b) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (flit_in.put) state <= S_RECV;
                S_RECV:  if (msg_done) state <= S_REQ;
                S_REQ:   if (ack) state <= S_DROP;
                S_DROP:  if (!ack) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign avail = (state == S_IDLE);
    assign req   = (state == S_REQ);

    // Local path values are stale for a header-only message and are
    // masked here
    always_ff @(posedge side_clk) begin
        if (state == S_RECV && msg_done) begin
            rec.hdr     <= hdr_word;
            rec.lcl_cnt <= lcl_asm_done ? lcl_dw_cnt : 3'd0;
            rec.lcl     <= lcl_asm_done ? lcl_word : '0;
            rec.perr    <= hdr_perr | (lcl_asm_done & lcl_perr);
        end
    end

    // ----------------------------------------------------------------------
    // Protocol checks
    // ----------------------------------------------------------------------

    // The sender must wait for avail before starting a message
    assert property (@(posedge side_clk) disable iff (!side_rst_b)
        flit_in.put |-> (state == S_IDLE || state == S_RECV))
        else $error("put while avail low and no message in progress");

    // The agent may sample rec at any point of the handshake
    assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (req || ack) |=> $stable(rec))
        else $error("record changed during delivery");

endmodule

`default_nettype wire

/* sb_dword_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

// Packs a flit stream into a word of one or more dwords
module sb_dword_assembler #(
    parameter int  PLD_WIDTH = `SB_PLD_WIDTH,
    parameter type out_t     = logic [`SB_DW_WIDTH-1:0]
) (
    input  logic                  side_clk,
    input  logic                  side_rst_b,
    input  sb_flit_pkg::sb_flit_t flit,
    output out_t                  word,
    output logic [2:0]            dw_cnt,
    output logic                  perr,
    output logic                  done
);

    import sb_flit_pkg::*;

    localparam int WORD_W       = $bits(out_t);
    localparam int WORD_DW      = WORD_W / `SB_DW_WIDTH;
    localparam int FLITS_PER_DW = `SB_DW_WIDTH / PLD_WIDTH;
    localparam int TOTAL        = WORD_W / PLD_WIDTH;
    localparam int IDX_W        = (TOTAL > 1) ? $clog2(TOTAL) : 1;

    logic [WORD_W-1:0] word_q;
    logic [IDX_W-1:0]  idx;
    logic              dw_last;
    logic              word_full;
    // Next put opens a new word; left set by eom or by a full word
    logic              restart;

    generate
        if (PLD_WIDTH != `SB_PLD_WIDTH) begin : g_width_err
            $error("PLD_WIDTH differs from the flit payload width");
        end
    endgenerate

    assign dw_last   = ((int'(idx) + 1) % FLITS_PER_DW) == 0;
    assign word_full = (idx == IDX_W'(TOTAL - 1));

    // ----------------------------------------------------------------------
    // Control, counts and parity
    // ----------------------------------------------------------------------

    always_ff @(posedge side_clk or negedge side_rst_b) begin
        if (!side_rst_b) begin
            idx     <= '0;
            dw_cnt  <= '0;
            perr    <= 1'b0;
            done    <= 1'b0;
            restart <= 1'b1;
        end else begin
            done <= flit.put & flit.eom;
            if (flit.put) begin
                idx     <= (flit.eom || word_full) ? '0 : idx + 1'b1;
                restart <= flit.eom || word_full;
                perr    <= (restart ? 1'b0 : perr) | flit_parity_err(flit);
                dw_cnt  <= (restart ? 3'd0 : dw_cnt) + (dw_last ? 3'd1 : 3'd0);
            end
        end
    end

    // Unused upper dwords of a new word read back as zero
    always_ff @(posedge side_clk) begin
        if (flit.put) begin
            if (restart) begin
                word_q <= '0;
            end
            word_q[int'(idx) * PLD_WIDTH +: PLD_WIDTH] <= flit.payload;
        end
    end

    assign word = out_t'(word_q);

    // A multi-dword word holds local data; filling it without eom means
    // the message has more local dwords than a record can count
    generate
        if (WORD_DW > 1) begin : g_ovf_chk
            assert property (@(posedge side_clk) disable iff (!side_rst_b)
                (flit.put && word_full) |-> flit.eom)
                else $error("more than %0d local dwords in one message", WORD_DW);
        end
    endgenerate

endmodule

`default_nettype wire

/* sb_hier_splitter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

// Separates the hierarchical header dword from the local payload dwords
module sb_hier_splitter #(
    parameter int PLD_WIDTH = `SB_PLD_WIDTH
) (
    input  logic                  side_clk,
    input  logic                  side_rst_b,
    input  sb_flit_pkg::sb_flit_t flit_in,
    output sb_flit_pkg::sb_flit_t hdr_flit,
    output sb_flit_pkg::sb_flit_t lcl_flit
);

    logic last_flit;
    // Set once the header dword has passed and the message goes on
    logic hdr_done;
    // msgip as the local path sees it, one dword behind the link
    logic lcl_msgip;

    sb_byte_counter #(
        .PLD_WIDTH (PLD_WIDTH)
    ) u_byte_counter (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .put        (flit_in.put),
        .last_flit  (last_flit)
    );

    // ----------------------------------------------------------------------
    // Routing state
    // ----------------------------------------------------------------------

    // The header ends with the first dword; a message that also ends
    // there never reaches the local path
    always_ff @(posedge side_clk or negedge side_rst_b) begin
        if (!side_rst_b) begin
            hdr_done <= 1'b0;
        end else if (flit_in.put) begin
            if (flit_in.eom) begin
                hdr_done <= 1'b0;
            end else if (last_flit) begin
                hdr_done <= 1'b1;
            end
        end
    end

    // Local msgip goes high after the first complete local dword and
    // drops again with the dword that carries eom
    always_ff @(posedge side_clk or negedge side_rst_b) begin
        if (!side_rst_b) begin
            lcl_msgip <= 1'b0;
        end else if (flit_in.put && last_flit && hdr_done) begin
            lcl_msgip <= !flit_in.eom;
        end
    end

    // ----------------------------------------------------------------------
    // Flit steering
    // ----------------------------------------------------------------------

    // The idle path is held at zero so its put can never fire
    always_comb begin
        hdr_flit = '0;
        lcl_flit = '0;
        if (hdr_done) begin
            lcl_flit       = flit_in;
            lcl_flit.msgip = lcl_msgip;
        end else begin
            hdr_flit = flit_in;
        end
    end

    // A message may only end on a dword boundary, otherwise the counter
    // would start the next message out of step
    assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (flit_in.put && flit_in.eom) |-> last_flit)
        else $error("eom in the middle of a dword");

endmodule

`default_nettype wire

/* sb_byte_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

// Tracks where the current flit sits inside its dword
module sb_byte_counter #(
    parameter int PLD_WIDTH = `SB_PLD_WIDTH
) (
    input  logic side_clk,
    input  logic side_rst_b,
    input  logic put,
    output logic last_flit
);

    localparam int FLITS = `SB_DW_WIDTH / PLD_WIDTH;

    generate
        if (FLITS == 1) begin : g_full_dw
            // Every put carries a whole dword, so each one is the last
            assign last_flit = put;
        end else begin : g_sub_dw
            localparam int IDX_W = $clog2(FLITS);

            logic [IDX_W-1:0] idx;

            // FLITS is a power of two, so the index wraps by itself
            // after the dword's final flit
            always_ff @(posedge side_clk or negedge side_rst_b) begin
                if (!side_rst_b) begin
                    idx <= '0;
                end else if (put) begin
                    idx <= idx + 1'b1;
                end
            end

            // Decoded from the count alone, users qualify it with put
            assign last_flit = (idx == IDX_W'(FLITS - 1));
        end
    endgenerate

endmodule

`default_nettype wire

/* sb_msg_pkg.sv */
`default_nettype none

`include "sb_settings.svh"

// Message level definitions used once the flits are packed into dwords
package sb_msg_pkg;

    // ----------------------------------------------------------------------
    // Hierarchical routing header
    // ----------------------------------------------------------------------

    // The first dword of every message; src_id sits in the low half so
    // it is carried by the first flits on the link
    typedef struct packed {
        logic [`SB_DW_WIDTH/2-1:0] dest_id;
        logic [`SB_DW_WIDTH/2-1:0] src_id;
    } sb_hier_hdr_t;

    // ----------------------------------------------------------------------
    // Local payload and the delivered record
    // ----------------------------------------------------------------------

    // Element 0 is the first local dword after the header
    typedef logic [`SB_MAX_LCL_DW-1:0][`SB_DW_WIDTH-1:0] sb_lcl_data_t;

    // Everything the agent receives for one message
    typedef struct packed {
        sb_hier_hdr_t hdr;
        // Number of valid entries in lcl, zero for a header-only message
        logic [2:0]   lcl_cnt;
        // Entries at and above lcl_cnt read as zero
        sb_lcl_data_t lcl;
        // Set if any flit of the message had bad parity
        logic         perr;
    } sb_msg_rec_t;

endpackage

`default_nettype wire

/* sb_flit_pkg.sv */
`default_nettype none

`include "sb_settings.svh"

// Link side definitions shared by the splitter, the assemblers and the ports
package sb_flit_pkg;

    // ----------------------------------------------------------------------
    // One flit of a channel as seen in a single cycle
    // ----------------------------------------------------------------------

    // Fields are only meaningful while put is high
    typedef struct packed {
        logic [`SB_PLD_WIDTH-1:0] payload;
        logic                     put;
        // High on every flit of a message except the one carrying eom
        logic                     msgip;
        logic                     eom;
        // Even parity over payload and this bit
        logic                     parity;
    } sb_flit_t;

    // Channel label, posted or non-posted
    typedef enum logic {
        PC = 1'b0,
        NP = 1'b1
    } sb_chan_e;

    // A flit has bad parity when payload and parity bit XOR to one
    function automatic logic flit_parity_err(sb_flit_t f);
        return ^{f.payload, f.parity};
    endfunction

endpackage

`default_nettype wire

/* sb_settings.svh */
`ifndef SB_SETTINGS_SVH
`define SB_SETTINGS_SVH

// ----------------------------------------------------------------------
// Link level sizing
// ----------------------------------------------------------------------

// Flit payload width in bits, one of 8, 16 or 32
`define SB_PLD_WIDTH 8

// A dword is the unit of the hierarchical header and of local data
`define SB_DW_WIDTH 32

// ----------------------------------------------------------------------
// Message level sizing
// ----------------------------------------------------------------------

// Local dwords that one buffered message can carry after its header
`define SB_MAX_LCL_DW 4

`endif
